/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_datapath
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
src/isa_pkg.sv
src/pipe_pkg.sv
src/reg_read.sv
src/operand_bypass.sv
src/execute_stage.sv
src/retire_stage.sv
src/datapath.sv
sim/tb_datapath.sv

/* sim/tb_datapath.sv */
//========================================
// datapath testbench
// table driven issue with random gaps,
// in-order result and flag checks
//========================================
`timescale 1ns/1ps

module tb_datapath;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RESET_CYCLES = 16;

    // one table row: issued op and what must come out of wb
    typedef struct packed {
        issue_t   op;
        word_t    data;
        reg_idx_t rd;
        nzcv_t    flags;
    } entry_t;

    logic   clk;
    logic   rst_n;
    logic   issue_valid;
    issue_t issue_op;
    wb_t    wb;
    nzcv_t  flags;

    entry_t tbl [$];
    logic   tbl_built;
    int     seed;
    int     n_seen;
    int     data_errors;
    int     rd_errors;
    int     wr_errors;
    int     flag_errors;
    int     seq_errors;

    datapath datapath_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .wb          (wb),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic issue_t make_op(alu_op_t op, reg_idx_t rd, reg_idx_t rn,
                                       logic use_imm, logic [11:0] val,
                                       logic reg_write, logic set_flags);
        issue_t o;
        o           = '0;
        o.rd        = rd;
        o.rn        = rn;
        o.use_imm   = use_imm;
        o.alu_op    = op;
        o.reg_write = reg_write;
        o.set_flags = set_flags;
        if (use_imm) begin
            o.opnd.imm12 = val;
        end else begin
            o.opnd.reg_view.rm = val[4:0];
        end
        return o;
    endfunction

    task automatic add_entry(issue_t op, word_t data, nzcv_t flg);
        tbl.push_back('{op: op, data: data, rd: op.rd, flags: flg});
    endtask

    task automatic push_imm_op(alu_op_t op, reg_idx_t rd, reg_idx_t rn, logic [11:0] imm,
                               logic sf, word_t data, nzcv_t flg);
        add_entry(make_op(op, rd, rn, 1'b1, imm, 1'b1, sf), data, flg);
    endtask

    task automatic push_reg_op(alu_op_t op, reg_idx_t rd, reg_idx_t rn, reg_idx_t rm,
                               logic sf, word_t data, nzcv_t flg);
        add_entry(make_op(op, rd, rn, 1'b0, {7'd0, rm}, 1'b1, sf), data, flg);
    endtask

    // expected flags are the running NZCV state after each op
    task automatic build_table();
        // dependent chain through the execute stage
        push_imm_op(ALU_ADD, 5'd1, 5'd31, 12'h005, 1'b0, 64'd5, 4'b0000);
        push_imm_op(ALU_ADD, 5'd2, 5'd1, 12'h003, 1'b0, 64'd8, 4'b0000);
        push_reg_op(ALU_ADD, 5'd3, 5'd2, 5'd1, 1'b0, 64'd13, 4'b0000);
        push_reg_op(ALU_ADD, 5'd4, 5'd3, 5'd3, 1'b0, 64'd26, 4'b0000);
        // distance two and three
        push_imm_op(ALU_ADD, 5'd6, 5'd31, 12'h100, 1'b0, 64'd256, 4'b0000);
        push_imm_op(ALU_ADD, 5'd7, 5'd31, 12'h200, 1'b0, 64'd512, 4'b0000);
        push_reg_op(ALU_ADD, 5'd8, 5'd6, 5'd3, 1'b0, 64'd269, 4'b0000);
        push_imm_op(ALU_ADD, 5'd9, 5'd31, 12'h001, 1'b0, 64'd1, 4'b0000);
        push_reg_op(ALU_ADD, 5'd10, 5'd6, 5'd7, 1'b0, 64'd768, 4'b0000);
        // two producers of X11, the younger one must win
        push_imm_op(ALU_ADD, 5'd11, 5'd31, 12'h00A, 1'b0, 64'd10, 4'b0000);
        push_imm_op(ALU_ADD, 5'd11, 5'd31, 12'h014, 1'b0, 64'd20, 4'b0000);
        push_imm_op(ALU_ADD, 5'd12, 5'd11, 12'h001, 1'b0, 64'd21, 4'b0000);
        // write to X31 shows on wb but X31 still reads zero
        push_imm_op(ALU_ADD, 5'd31, 5'd31, 12'h7FF, 1'b0, 64'd2047, 4'b0000);
        push_reg_op(ALU_ADD, 5'd12, 5'd31, 5'd31, 1'b0, 64'd0, 4'b0000);
        // rm bits of 0xF8C name X12, which was just written
        push_imm_op(ALU_ADD, 5'd14, 5'd1, 12'hF8C, 1'b0, 64'd3985, 4'b0000);
        // borrow, then zero result without borrow
        push_imm_op(ALU_SUB, 5'd21, 5'd31, 12'h001, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF, 4'b1000);
        push_imm_op(ALU_SUB, 5'd25, 5'd1, 12'h005, 1'b1, 64'd0, 4'b0110);
        push_imm_op(ALU_ADD, 5'd26, 5'd25, 12'h007, 1'b0, 64'd7, 4'b0110);
        // double up to 2**63 for the signed overflow case
        push_imm_op(ALU_ADD, 5'd23, 5'd31, 12'h800, 1'b0, 64'd2048, 4'b0110);
        for (int i = 0; i < 52; i++) begin
            push_reg_op(ALU_ADD, 5'd23, 5'd23, 5'd23, 1'b0, 64'd2048 << (i + 1), 4'b0110);
        end
        push_imm_op(ALU_SUB, 5'd24, 5'd23, 12'h001, 1'b1, 64'h7FFF_FFFF_FFFF_FFFF, 4'b0011);
        push_imm_op(ALU_ADD, 5'd5, 5'd2, 12'h000, 1'b0, 64'd8, 4'b0011);
        // logic ops clear C and V
        push_reg_op(ALU_AND, 5'd27, 5'd24, 5'd21, 1'b1, 64'h7FFF_FFFF_FFFF_FFFF, 4'b0000);
        push_reg_op(ALU_ORR, 5'd28, 5'd23, 5'd24, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF, 4'b1000);
        push_imm_op(ALU_EOR, 5'd29, 5'd28, 12'hFFF, 1'b0, 64'hFFFF_FFFF_FFFF_F000, 4'b1000);
        push_reg_op(ALU_EOR, 5'd30, 5'd29, 5'd29, 1'b1, 64'd0, 4'b0100);
        push_imm_op(ALU_AND, 5'd16, 5'd28, 12'h0F0, 1'b0, 64'h0F0, 4'b0100);
        // retires without writing, so X17 stays zero
        add_entry(make_op(ALU_ADD, 5'd17, 5'd1, 1'b1, 12'h001, 1'b0, 1'b0), 64'd6, 4'b0100);
        push_imm_op(ALU_ADD, 5'd18, 5'd17, 12'h000, 1'b0, 64'd0, 4'b0100);
    endtask

    task automatic print_counts();
        $display("errors: data %0d, rd %0d, reg_write %0d, flags %0d, sequence %0d",
                 data_errors, rd_errors, wr_errors, flag_errors, seq_errors);
    endtask

    // result checker, one wb.valid per table row in order
    always @(posedge clk) begin
        entry_t want;
        if (rst_n && wb.valid) begin
            assert (n_seen < tbl.size())
                else begin
                    seq_errors++;
                    $display("result on wb at %0t with no operation left to retire", $time);
                end
            if (n_seen < tbl.size()) begin
                want = tbl[n_seen];
                assert (wb.data == want.data)
                    else begin
                        data_errors++;
                        $display("** Error at %0t: wb.data expected %h, actual %h (entry %0d)",
                                 $time, want.data, wb.data, n_seen);
                    end
                assert (wb.rd == want.rd)
                    else begin
                        rd_errors++;
                        $display("** Error at %0t: wb.rd expected %0d, actual %0d (entry %0d)",
                                 $time, want.rd, wb.rd, n_seen);
                    end
                assert (wb.reg_write == want.op.reg_write)
                    else begin
                        wr_errors++;
                        $display("** Error at %0t: wb.reg_write expected %b, actual %b",
                                 $time, want.op.reg_write, wb.reg_write);
                    end
                // three edges after issue the flags hold this op's outcome
                assert (flags == want.flags)
                    else begin
                        flag_errors++;
                        $display("** Error at %0t: flags expected %b, actual %b (entry %0d)",
                                 $time, want.flags, flags, n_seen);
                    end
            end
            n_seen++;
        end
    end

    initial begin
        int limit_ns;
        wait (tbl_built);
        limit_ns = (RESET_CYCLES + tbl.size() * 3 + RESULT_LATENCY + 10) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout: only %0d of %0d results reached wb", n_seen, tbl.size());
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int gap;
        seed        = 6;
        n_seen      = 0;
        data_errors = 0;
        rd_errors   = 0;
        wr_errors   = 0;
        flag_errors = 0;
        seq_errors  = 0;
        tbl_built   = 1'b0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = '0;
        build_table();
        tbl_built = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        foreach (tbl[i]) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                issue_valid <= 1'b0;
            end
            @(posedge clk);
            issue_valid <= 1'b1;
            issue_op    <= tbl[i].op;
        end
        @(posedge clk);
        issue_valid <= 1'b0;

        wait (n_seen >= tbl.size());
        repeat (4) @(posedge clk);
        print_counts();
        if (data_errors + rd_errors + wr_errors + flag_errors + seq_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src/datapath.sv */
//========================================
// integer datapath top level
// register read, bypass, execute and
// retire stages
//========================================
`timescale 1ns/1ps

module datapath (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  isa_pkg::issue_t issue_op,
    output pipe_pkg::wb_t   wb,
    output pipe_pkg::nzcv_t flags
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic     rf_valid;
    issue_t   rf_op;
    reg_idx_t src_reg  [NUM_READ_PORTS];
    word_t    raw_data [NUM_READ_PORTS];
    word_t    byp_data [NUM_READ_PORTS];
    fwd_t     ex_fwd;
    fwd_t     wb_fwd;

    // the write-back register is the second forwarding source
    assign wb_fwd = fwd_t'(wb);

    reg_read reg_read_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .wb          (wb),
        .rf_valid    (rf_valid),
        .rf_op       (rf_op),
        .src_reg     (src_reg),
        .raw_data    (raw_data)
    );

    // one bypass unit per read port, rn then rm
    for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_bypass
        operand_bypass operand_bypass_inst (
            .src    (src_reg[p]),
            .raw    (raw_data[p]),
            .ex_fwd (ex_fwd),
            .wb_fwd (wb_fwd),
            .data   (byp_data[p])
        );
    end

    execute_stage execute_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rf_valid (rf_valid),
        .rf_op    (rf_op),
        .opnd_a   (byp_data[0]),
        .opnd_b   (byp_data[1]),
        .ex_fwd   (ex_fwd),
        .flags    (flags)
    );

    retire_stage retire_stage_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_fwd (ex_fwd),
        .wb     (wb)
    );

endmodule

/* src/execute_stage.sv */
//========================================
// execute stage
// operand register, ALU and the NZCV flag
// register
//========================================
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rf_valid,
    input  isa_pkg::issue_t rf_op,
    input  pipe_pkg::word_t opnd_a,
    input  pipe_pkg::word_t opnd_b,
    output pipe_pkg::fwd_t  ex_fwd,
    output pipe_pkg::nzcv_t flags
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic            ex_valid;
    issue_t          ex_op;
    word_t           a_q;
    word_t           b_q;
    word_t           b_opnd;
    word_t           b_add;
    word_t           result;
    logic            is_sub;
    logic [DATA_W:0] sum;
    logic            carry;
    logic            ovf;
    nzcv_t           next_flags;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= rf_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op <= rf_op;
        a_q   <= opnd_a;
        b_q   <= opnd_b;
    end

    // imm12 view, zero extended
    assign b_opnd = ex_op.use_imm ? {{(DATA_W-IMM_W){1'b0}}, ex_op.opnd.imm12} : b_q;

    // subtract as A + ~B + 1
    assign is_sub = (ex_op.alu_op == ALU_SUB);
    assign b_add  = is_sub ? ~b_opnd : b_opnd;
    assign sum    = {1'b0, a_q} + {1'b0, b_add} + {{DATA_W{1'b0}}, is_sub};

    always_comb begin
        carry  = 1'b0;
        ovf    = 1'b0;
        case (ex_op.alu_op)
            ALU_ADD, ALU_SUB: begin
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];
                // same-sign inputs, different-sign result
                ovf    = (a_q[DATA_W-1] == b_add[DATA_W-1]) &&
                         (result[DATA_W-1] != a_q[DATA_W-1]);
            end
            ALU_AND: result = a_q & b_opnd;
            ALU_ORR: result = a_q | b_opnd;
            ALU_EOR: result = a_q ^ b_opnd;
            default: result = '0;
        endcase
    end

    assign next_flags = '{n: result[DATA_W-1], z: (result == '0), c: carry, v: ovf};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ex_valid && ex_op.set_flags) begin
            flags <= next_flags;
        end
    end

    assign ex_fwd = '{valid: ex_valid, reg_write: ex_op.reg_write, rd: ex_op.rd, data: result};

    // flags only move one edge after a valid flag-setting op
    assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_valid && ex_op.set_flags) |=> $stable(flags))
        else $error("flags changed without a flag-setting operation");

endmodule

/* src/isa_pkg.sv */
//========================================
// instruction set package
// register numbers, ALU operations and the
// decoded operation handed to the core
//========================================
package isa_pkg;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    // reads as zero, writes are dropped
    localparam reg_idx_t ZERO_REG = 5'd31;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_ORR = 3'd3,
        ALU_EOR = 3'd4
    } alu_op_t;

    // register view of the second operand field
    typedef struct packed {
        logic [6:0] pad;
        reg_idx_t   rm;
    } opnd_reg_t;

    // same 12 bits, decoded as rm or as imm12 depending on use_imm
    typedef union packed {
        opnd_reg_t   reg_view;
        logic [11:0] imm12;
    } operand_field_t;

    typedef struct packed {
        reg_idx_t       rd;
        reg_idx_t       rn;
        operand_field_t opnd;
        logic           use_imm;
        alu_op_t        alu_op;
        logic           reg_write;
        logic           set_flags;
    } issue_t;

endpackage

/* src/operand_bypass.sv */
//========================================
// operand bypass
// picks register file, execute or
// write-back value for one read port
//========================================
`timescale 1ns/1ps

module operand_bypass (
    input  isa_pkg::reg_idx_t src,
    input  pipe_pkg::word_t   raw,
    input  pipe_pkg::fwd_t    ex_fwd,
    input  pipe_pkg::fwd_t    wb_fwd,
    output pipe_pkg::word_t   data
);
    import isa_pkg::*;

    logic ex_hit;
    logic wb_hit;

    assign ex_hit = ex_fwd.valid && ex_fwd.reg_write && (ex_fwd.rd == src);
    assign wb_hit = wb_fwd.valid && wb_fwd.reg_write && (wb_fwd.rd == src);

    // younger producer (execute) wins over write-back
    always_comb begin
        if (src == ZERO_REG) begin
            data = '0;
            // a stage writing X31 may match here, its value is never taken
            assert final (raw == '0)
                else $error("X31 selected with nonzero register file value");
        end else if (ex_hit) begin
            data = ex_fwd.data;
        end else if (wb_hit) begin
            data = wb_fwd.data;
        end else begin
            data = raw;
        end
    end

endmodule

/* src/pipe_pkg.sv */
//========================================
// pipeline package
// data width, flags and the records that
// move between the pipeline stages
//========================================
package pipe_pkg;

    localparam int DATA_W         = 64;
    localparam int IMM_W          = 12;
    localparam int NUM_READ_PORTS = 2;
    // edges from the issue edge to the edge that samples wb
    localparam int RESULT_LATENCY = 3;

    typedef logic [DATA_W-1:0] word_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

    // result offered by a producing stage for forwarding
    typedef struct packed {
        logic              valid;
        logic              reg_write;
        isa_pkg::reg_idx_t rd;
        word_t             data;
    } fwd_t;

    // write-back record, also the register file write port
    typedef struct packed {
        logic              valid;
        logic              reg_write;
        isa_pkg::reg_idx_t rd;
        word_t             data;
    } wb_t;

endpackage

/* src/reg_read.sv */
//========================================
// register read stage
// 32 x 64 register file, issue register
// and the raw operand read for both ports
//========================================
`timescale 1ns/1ps

module reg_read (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  isa_pkg::issue_t   issue_op,
    input  pipe_pkg::wb_t     wb,
    output logic              rf_valid,
    output isa_pkg::issue_t   rf_op,
    output isa_pkg::reg_idx_t src_reg  [pipe_pkg::NUM_READ_PORTS],
    output pipe_pkg::word_t   raw_data [pipe_pkg::NUM_READ_PORTS]
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t regs [2**$bits(reg_idx_t)];
    logic  wr_en;

    // X31 is never written
    assign wr_en = wb.valid && wb.reg_write && (wb.rd != ZERO_REG);

    // write lands at the edge ending the wb cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < $size(regs); r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rf_valid <= 1'b0;
        end else begin
            rf_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rf_op <= issue_op;
        end
    end

    // port 0 reads rn, port 1 reads rm or X31 for immediate ops
    assign src_reg[0] = rf_op.rn;
    assign src_reg[1] = rf_op.use_imm ? ZERO_REG : rf_op.opnd.reg_view.rm;

    always_comb begin
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            raw_data[p] = regs[src_reg[p]];
        end
    end

    // the zero register holds zero in every cycle after reset
    assert property (@(posedge clk) disable iff (!rst_n) regs[ZERO_REG] == '0)
        else $error("register file entry X31 is not zero");

endmodule

/* src/retire_stage.sv */
//========================================
// retire stage
// write-back register feeding the register
// file, forwarding and the result outputs
//========================================
`timescale 1ns/1ps

module retire_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  pipe_pkg::fwd_t ex_fwd,
    output pipe_pkg::wb_t  wb
);

    // every valid op retires here, with or without reg_write
    always_ff @(posedge clk) begin
        wb.reg_write <= ex_fwd.reg_write;
        wb.rd        <= ex_fwd.rd;
        wb.data      <= ex_fwd.data;
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex_fwd.valid;
        end
    end

endmodule
